// File: axi_adapter_pkg.sv
// AXI adapter package with shared widths, core payloads and AXI-Lite channel types
package axi_adapter_pkg;

    localparam int DATA_WIDTH       = 32;
    localparam int BYTEEN_WIDTH     = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH_IN    = 30;
    localparam int ADDR_WIDTH_OUT   = 32;
    localparam int WORD_OFFSET_BITS = 2;
    localparam int TAG_WIDTH        = 8;
    // Index plus port field must fit here
    localparam int AXI_ID_WIDTH     = 8;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // Core side request and response
    typedef struct packed {
        logic                    rw;
        logic [ADDR_WIDTH_IN-1:0] addr;
        logic [BYTEEN_WIDTH-1:0] byteen;
        logic [DATA_WIDTH-1:0]   data;
        logic [TAG_WIDTH-1:0]    tag;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [TAG_WIDTH-1:0]  tag;
    } mem_rsp_t;

    // Internal request after tag substitution, still word addressed
    typedef struct packed {
        logic                     rw;
        logic [ADDR_WIDTH_IN-1:0] addr;
        logic [BYTEEN_WIDTH-1:0]  byteen;
        logic [DATA_WIDTH-1:0]    data;
        logic [AXI_ID_WIDTH-1:0]  id;
    } axi_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [AXI_ID_WIDTH-1:0] id;
    } axi_rsp_t;

    typedef struct packed {
        logic [ADDR_WIDTH_OUT-1:0] addr;
        logic [AXI_ID_WIDTH-1:0]   id;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [BYTEEN_WIDTH-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [ADDR_WIDTH_OUT-1:0] addr;
        logic [AXI_ID_WIDTH-1:0]   id;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [AXI_ID_WIDTH-1:0] id;
        logic [1:0]              resp;
    } axi_r_t;

    typedef struct packed {
        logic [AXI_ID_WIDTH-1:0] id;
        logic [1:0]              resp;
    } axi_b_t;

endpackage

// File: tag_index_buffer.sv
// Tag index buffer that parks read tags in a small table and hands out entry indices
`timescale 1ns/1ps

module tag_index_buffer #(
    parameter int TAG_BUFFER_SIZE = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 acquire,
    input  logic [axi_adapter_pkg::TAG_WIDTH-1:0] tag_in,
    input  logic                                 release_en,
    input  logic [$clog2(TAG_BUFFER_SIZE)-1:0]   release_index,
    output logic [$clog2(TAG_BUFFER_SIZE)-1:0]   acquire_index,
    output logic [axi_adapter_pkg::TAG_WIDTH-1:0] tag_out,
    output logic                                 full
);

    localparam int INDEX_WIDTH = $clog2(TAG_BUFFER_SIZE);

    logic [TAG_BUFFER_SIZE-1:0]            live_q;
    logic [axi_adapter_pkg::TAG_WIDTH-1:0] tag_mem [TAG_BUFFER_SIZE];

    // Lowest free entry wins, so scan from the top down
    always_comb begin
        acquire_index = '0;
        for (int i = TAG_BUFFER_SIZE - 1; i >= 0; i--) begin
            if (!live_q[i]) begin
                acquire_index = INDEX_WIDTH'(i);
            end
        end
    end

    assign full    = &live_q;
    assign tag_out = tag_mem[release_index];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            live_q <= '0;
        end else begin
            if (acquire && !full) begin
                live_q[acquire_index] <= 1'b1;
            end
            // Acquire never picks a live entry, so both may happen together
            if (release_en) begin
                live_q[release_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire && !full) begin
            tag_mem[acquire_index] <= tag_in;
        end
    end

endmodule

// File: stream_reg.sv
// Stream register holding one payload of any type between two valid/ready stages
`timescale 1ns/1ps

module stream_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic full_q;

    // Refill in the same cycle the entry drains
    assign in_ready  = !full_q || out_ready;
    assign out_valid = full_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            full_q <= 1'b1;
        end else if (out_ready) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: req_arbiter.sv
// Round-robin request arbiter that tags the winning request with its port number
`timescale 1ns/1ps

module req_arbiter #(
    parameter int NUM_PORTS = 2
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [NUM_PORTS-1:0]                        in_valid,
    input  axi_adapter_pkg::axi_req_t [NUM_PORTS-1:0]   in_req,
    output logic [NUM_PORTS-1:0]                        in_ready,
    output logic                                        out_valid,
    output axi_adapter_pkg::axi_req_t                   out_req,
    input  logic                                        out_ready
);

    localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int ID_W      = axi_adapter_pkg::AXI_ID_WIDTH;

    logic [PORT_BITS-1:0] ptr_q;
    logic [PORT_BITS-1:0] grant;

    // First valid port at or after the pointer
    always_comb begin
        int idx;
        grant = ptr_q;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            idx = (int'(ptr_q) + i) % NUM_PORTS;
            if (in_valid[idx]) begin
                grant = PORT_BITS'(idx);
            end
        end
    end

    assign out_valid = |in_valid;

    // Idle ports show ready, only the granted one can transfer
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_ready
        assign in_ready[i] = out_ready && (!in_valid[i] || grant == PORT_BITS'(i));
    end

    always_comb begin
        out_req    = in_req[grant];
        out_req.id = {in_req[grant].id[ID_W-PORT_BITS-1:0], grant};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (out_valid && out_ready) begin
            ptr_q <= (grant == PORT_BITS'(NUM_PORTS - 1)) ? '0 : grant + 1'b1;
        end
    end

endmodule

// File: axi_req_master.sv
// AXI request master issuing AW/W or AR for one request and tracking write acceptance
`timescale 1ns/1ps

module axi_req_master (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  axi_adapter_pkg::axi_req_t req,
    output logic                      req_ready,
    output logic                      aw_valid,
    output axi_adapter_pkg::axi_aw_t  aw,
    input  logic                      aw_ready,
    output logic                      w_valid,
    output axi_adapter_pkg::axi_w_t   w,
    input  logic                      w_ready,
    output logic                      ar_valid,
    output axi_adapter_pkg::axi_ar_t  ar,
    input  logic                      ar_ready
);

    localparam int OUT_W = axi_adapter_pkg::ADDR_WIDTH_OUT;

    logic [OUT_W-1:0] byte_addr;
    logic             aw_done_q;
    logic             w_done_q;
    logic             aw_fire;
    logic             w_fire;
    logic             write_done;

    // Word address to byte address
    assign byte_addr = OUT_W'(req.addr) << axi_adapter_pkg::WORD_OFFSET_BITS;

    // A channel already accepted drops out until its partner catches up
    assign aw_valid = req_valid && req.rw && !aw_done_q;
    assign w_valid  = req_valid && req.rw && !w_done_q;
    assign ar_valid = req_valid && !req.rw;

    assign aw.addr = byte_addr;
    assign aw.id   = req.id;
    assign w.data  = req.data;
    assign w.strb  = req.byteen;
    assign ar.addr = byte_addr;
    assign ar.id   = req.id;

    assign aw_fire    = aw_valid && aw_ready;
    assign w_fire     = w_valid && w_ready;
    assign write_done = (aw_done_q || aw_fire) && (w_done_q || w_fire);

    assign req_ready = req.rw ? write_done : ar_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else if (req_valid && req.rw && write_done) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_done_q <= 1'b1;
            end
            if (w_fire) begin
                w_done_q <= 1'b1;
            end
        end
    end

endmodule

// File: axi_rsp_router.sv
// AXI response router that buffers R data and steers it to the port named in the ID
`timescale 1ns/1ps

module axi_rsp_router #(
    parameter int NUM_PORTS = 2
) (
    input  logic                      r_valid,
    input  axi_adapter_pkg::axi_r_t   r,
    output logic                      r_ready,
    input  logic                      b_valid,
    input  axi_adapter_pkg::axi_b_t   b,
    output logic                      b_ready,
    output logic                      buf_in_valid,
    output axi_adapter_pkg::axi_rsp_t buf_in,
    input  logic                      buf_in_ready,
    input  logic                      out_valid_in,
    input  axi_adapter_pkg::axi_rsp_t out_rsp,
    output logic                      out_ready_in,
    output logic [NUM_PORTS-1:0]      port_valid,
    input  logic [NUM_PORTS-1:0]      port_ready,
    output logic [NUM_PORTS-1:0][axi_adapter_pkg::AXI_ID_WIDTH
                                 - ((NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1) - 1:0] port_index
);

    localparam int PORT_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int ID_W      = axi_adapter_pkg::AXI_ID_WIDTH;

    logic [PORT_BITS-1:0] port_sel;

    // Write responses carry nothing the cores need
    assign b_ready = 1'b1;

    assign buf_in_valid = r_valid;
    assign buf_in.data  = r.data;
    assign buf_in.id    = r.id;
    assign r_ready      = buf_in_ready;

    assign port_sel     = out_rsp.id[PORT_BITS-1:0];
    assign out_ready_in = port_ready[port_sel];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assign port_valid[i] = out_valid_in && (port_sel == PORT_BITS'(i));
        assign port_index[i] = out_rsp.id[ID_W-1:PORT_BITS];
    end

endmodule

// File: axi_adapter.sv
// Memory-request to AXI adapter sharing one AXI-Lite master among several core ports
`timescale 1ns/1ps

module axi_adapter #(
    parameter int NUM_PORTS       = 2,
    parameter int TAG_BUFFER_SIZE = 8
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [NUM_PORTS-1:0]                      req_valid,
    input  axi_adapter_pkg::mem_req_t [NUM_PORTS-1:0] req,
    output logic [NUM_PORTS-1:0]                      req_ready,
    output logic [NUM_PORTS-1:0]                      rsp_valid,
    output axi_adapter_pkg::mem_rsp_t [NUM_PORTS-1:0] rsp,
    input  logic [NUM_PORTS-1:0]                      rsp_ready,
    output logic                                      aw_valid,
    output axi_adapter_pkg::axi_aw_t                  aw,
    input  logic                                      aw_ready,
    output logic                                      w_valid,
    output axi_adapter_pkg::axi_w_t                   w,
    input  logic                                      w_ready,
    output logic                                      ar_valid,
    output axi_adapter_pkg::axi_ar_t                  ar,
    input  logic                                      ar_ready,
    input  logic                                      r_valid,
    input  axi_adapter_pkg::axi_r_t                   r,
    output logic                                      r_ready,
    input  logic                                      b_valid,
    input  axi_adapter_pkg::axi_b_t                   b,
    output logic                                      b_ready
);

    localparam int INDEX_WIDTH = $clog2(TAG_BUFFER_SIZE);
    localparam int PORT_BITS   = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int ID_W        = axi_adapter_pkg::AXI_ID_WIDTH;

    logic [NUM_PORTS-1:0]                             tbuf_full;
    logic [NUM_PORTS-1:0][INDEX_WIDTH-1:0]            acq_index;
    logic [NUM_PORTS-1:0][axi_adapter_pkg::TAG_WIDTH-1:0] rsp_tag;
    logic [NUM_PORTS-1:0][ID_W-PORT_BITS-1:0]         rsp_index;
    logic [NUM_PORTS-1:0]                             arb_valid;
    logic [NUM_PORTS-1:0]                             arb_ready;
    axi_adapter_pkg::axi_req_t [NUM_PORTS-1:0]        arb_req;

    logic                      sel_valid, sel_ready, mst_valid, mst_ready;
    axi_adapter_pkg::axi_req_t sel_req, mst_req;
    logic                      rbuf_in_valid, rbuf_in_ready, rbuf_valid, rbuf_ready;
    axi_adapter_pkg::axi_rsp_t rbuf_in, rbuf;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        logic tag_ok;

        // Reads need a free index, writes pass their tag straight through
        assign tag_ok       = req[i].rw || !tbuf_full[i];
        assign arb_valid[i] = req_valid[i] && tag_ok;
        assign req_ready[i] = arb_ready[i] && tag_ok;
        assign arb_req[i]   = '{rw: req[i].rw, addr: req[i].addr, byteen: req[i].byteen,
                                data: req[i].data,
                                id: req[i].rw ? ID_W'(req[i].tag) : ID_W'(acq_index[i])};
        assign rsp[i]       = '{data: rbuf.data, tag: rsp_tag[i]};

        tag_index_buffer #(.TAG_BUFFER_SIZE(TAG_BUFFER_SIZE)) i_tag_buf (
            .clk(clk), .rst_n(rst_n),
            .acquire(req_valid[i] && req_ready[i] && !req[i].rw), .tag_in(req[i].tag),
            .release_en(rsp_valid[i] && rsp_ready[i]),
            .release_index(rsp_index[i][INDEX_WIDTH-1:0]),
            .acquire_index(acq_index[i]), .tag_out(rsp_tag[i]), .full(tbuf_full[i])
        );
    end

    req_arbiter #(.NUM_PORTS(NUM_PORTS)) i_arbiter (
        .clk(clk), .rst_n(rst_n), .in_valid(arb_valid), .in_req(arb_req), .in_ready(arb_ready),
        .out_valid(sel_valid), .out_req(sel_req), .out_ready(sel_ready)
    );

    stream_reg #(.payload_t(axi_adapter_pkg::axi_req_t)) i_req_reg (
        .clk(clk), .rst_n(rst_n), .in_valid(sel_valid), .in_data(sel_req), .in_ready(sel_ready),
        .out_valid(mst_valid), .out_data(mst_req), .out_ready(mst_ready)
    );

    axi_req_master i_master (
        .clk(clk), .rst_n(rst_n), .req_valid(mst_valid), .req(mst_req), .req_ready(mst_ready),
        .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready), .w_valid(w_valid), .w(w),
        .w_ready(w_ready), .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready)
    );

    axi_rsp_router #(.NUM_PORTS(NUM_PORTS)) i_router (
        .r_valid(r_valid), .r(r), .r_ready(r_ready), .b_valid(b_valid), .b(b),
        .b_ready(b_ready), .buf_in_valid(rbuf_in_valid), .buf_in(rbuf_in),
        .buf_in_ready(rbuf_in_ready), .out_valid_in(rbuf_valid), .out_rsp(rbuf),
        .out_ready_in(rbuf_ready), .port_valid(rsp_valid), .port_ready(rsp_ready),
        .port_index(rsp_index)
    );

    stream_reg #(.payload_t(axi_adapter_pkg::axi_rsp_t)) i_rsp_reg (
        .clk(clk), .rst_n(rst_n), .in_valid(rbuf_in_valid), .in_data(rbuf_in),
        .in_ready(rbuf_in_ready), .out_valid(rbuf_valid), .out_data(rbuf),
        .out_ready(rbuf_ready)
    );

endmodule

// File: axi_adapter_sva.sv
// Assertions on the AXI adapter's AXI request channels, response ports and reset state
`timescale 1ns/1ps

module axi_adapter_sva #(
    parameter int NUM_PORTS = 2
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     aw_valid,
    input axi_adapter_pkg::axi_aw_t aw,
    input logic                     aw_ready,
    input logic                     w_valid,
    input axi_adapter_pkg::axi_w_t  w,
    input logic                     w_ready,
    input logic                     ar_valid,
    input axi_adapter_pkg::axi_ar_t ar,
    input logic                     ar_ready,
    input logic [NUM_PORTS-1:0]     rsp_valid
);

    int unsigned fail_count = 0;

    // Stalled AXI payloads hold
    assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> $stable(aw))
    else begin
        $error("AW payload changed while AW was stalled");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready |=> $stable(w))
    else begin
        $error("W payload changed while W was stalled");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> $stable(ar))
    else begin
        $error("AR payload changed while AR was stalled");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rsp_valid))
    else begin
        $error("Response valid raised on more than one port");
        fail_count++;
    end

    // One edge in reset clears every valid
    assert property (@(posedge clk)
        !rst_n |=> !aw_valid && !w_valid && !ar_valid && rsp_valid == '0)
    else begin
        $error("Output valid high during reset");
        fail_count++;
    end

endmodule

bind axi_adapter axi_adapter_sva #(.NUM_PORTS(NUM_PORTS)) i_sva (.*);

// File: tb_axi_adapter.sv
// Testbench for the AXI adapter with an inline AXI memory model and a table of requests
`timescale 1ns/1ps

module tb_axi_adapter;

    typedef struct packed {
        logic        port;
        logic        rw;
        logic [29:0] addr;
        logic [3:0]  byteen;
        logic [31:0] data;
        logic [7:0]  tag;
        logic [31:0] exp_data;
        logic        stall;
    } row_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } wr_exp_t;

    localparam int NUM_ROWS = 22;

    // Columns are port, rw, word addr, byteen, data, tag, expected read data, stall
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b0, 1'b1, 30'h10, 4'hF, 32'h1122_3344, 8'h05, 32'h0, 1'b0},
        '{1'b0, 1'b1, 30'h10, 4'h5, 32'hAABB_CCDD, 8'h06, 32'h0, 1'b0},
        '{1'b0, 1'b0, 30'h10, 4'h0, 32'h0, 8'h21, 32'h11BB_33DD, 1'b0},
        '{1'b1, 1'b1, 30'h20, 4'hF, 32'h5566_7788, 8'h05, 32'h0, 1'b0},
        '{1'b1, 1'b1, 30'h20, 4'hA, 32'h99AA_BBCC, 8'h06, 32'h0, 1'b0},
        '{1'b1, 1'b0, 30'h20, 4'h0, 32'h0, 8'h21, 32'h9966_BB88, 1'b0},
        '{1'b0, 1'b0, 30'h10, 4'h0, 32'h0, 8'h30, 32'h11BB_33DD, 1'b0},
        '{1'b1, 1'b0, 30'h20, 4'h0, 32'h0, 8'h30, 32'h9966_BB88, 1'b0},
        '{1'b0, 1'b0, 30'h41, 4'h0, 32'h0, 8'h31, 32'hC0DE_0041, 1'b0},
        '{1'b1, 1'b0, 30'h52, 4'h0, 32'h0, 8'h31, 32'hC0DE_0052, 1'b0},
        '{1'b0, 1'b0, 30'h63, 4'h0, 32'h0, 8'h32, 32'hC0DE_0063, 1'b0},
        '{1'b1, 1'b0, 30'h74, 4'h0, 32'h0, 8'h32, 32'hC0DE_0074, 1'b0},
        '{1'b0, 1'b0, 30'h80, 4'h0, 32'h0, 8'h80, 32'hC0DE_0080, 1'b0},
        '{1'b0, 1'b0, 30'h81, 4'h0, 32'h0, 8'h81, 32'hC0DE_0081, 1'b0},
        '{1'b0, 1'b0, 30'h82, 4'h0, 32'h0, 8'h82, 32'hC0DE_0082, 1'b0},
        '{1'b0, 1'b0, 30'h83, 4'h0, 32'h0, 8'h83, 32'hC0DE_0083, 1'b0},
        '{1'b0, 1'b0, 30'h84, 4'h0, 32'h0, 8'h84, 32'hC0DE_0084, 1'b0},
        '{1'b0, 1'b0, 30'h85, 4'h0, 32'h0, 8'h85, 32'hC0DE_0085, 1'b0},
        '{1'b0, 1'b0, 30'h86, 4'h0, 32'h0, 8'h86, 32'hC0DE_0086, 1'b0},
        '{1'b0, 1'b0, 30'h87, 4'h0, 32'h0, 8'h87, 32'hC0DE_0087, 1'b0},
        '{1'b0, 1'b1, 30'h90, 4'hF, 32'hDEAD_BEEF, 8'h44, 32'h0, 1'b0},
        '{1'b0, 1'b0, 30'h90, 4'h0, 32'h0, 8'h99, 32'hDEAD_BEEF, 1'b1}
    };

    logic clk, rst_n;
    logic [1:0] req_valid, req_ready, rsp_valid, rsp_ready;
    axi_adapter_pkg::mem_req_t [1:0] req;
    axi_adapter_pkg::mem_rsp_t [1:0] rsp;
    logic aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
    logic r_valid, r_ready, b_valid, b_ready;
    axi_adapter_pkg::axi_aw_t aw;
    axi_adapter_pkg::axi_w_t  w;
    axi_adapter_pkg::axi_ar_t ar;
    axi_adapter_pkg::axi_r_t  r;
    axi_adapter_pkg::axi_b_t  b;

    logic [31:0] mem [256];
    logic [31:0] lcg_state = 32'h8d68;
    logic        hold_r, check_alt, have_last, last_port, b_next;
    int          errors = 0;
    int          r_wait = 0;

    axi_adapter_pkg::axi_aw_t  aw_q [$];
    axi_adapter_pkg::axi_w_t   w_q [$];
    axi_adapter_pkg::axi_r_t   r_q [$];
    wr_exp_t                   wr_exp_q [2][$];
    axi_adapter_pkg::mem_rsp_t rd_exp_q [2][$];
    logic [31:0]               rd_addr_q [2][$];

    axi_adapter #(.NUM_PORTS(2), .TAG_BUFFER_SIZE(8)) i_axi_adapter (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pending_count();
        return rd_exp_q[0].size() + rd_exp_q[1].size() + wr_exp_q[0].size() + wr_exp_q[1].size();
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    // Holds one request until the port accepts it
    task automatic send_row(input int i);
        int p;
        p = int'(ROWS[i].port);
        req[p] = axi_adapter_pkg::mem_req_t'{rw: ROWS[i].rw, addr: ROWS[i].addr,
            byteen: ROWS[i].byteen, data: ROWS[i].data, tag: ROWS[i].tag};
        req_valid[p] = 1'b1;
        if (ROWS[i].stall) begin
            repeat (10) begin
                @(posedge clk);
                check_value("req_ready", 32'd0, 32'(req_ready[p]));
            end
            hold_r = 1'b0;
        end
        do begin
            @(posedge clk);
        end while (!req_ready[p]);
        if (ROWS[i].rw) begin
            wr_exp_q[p].push_back(wr_exp_t'{addr: 32'(ROWS[i].addr) * 4, data: ROWS[i].data,
                                             strb: ROWS[i].byteen});
        end else begin
            rd_exp_q[p].push_back(axi_adapter_pkg::mem_rsp_t'{data: ROWS[i].exp_data,
                                                             tag: ROWS[i].tag});
            rd_addr_q[p].push_back(32'(ROWS[i].addr) * 4);
        end
        #1;
        req_valid[p] = 1'b0;
    endtask

    task automatic drive_port(input int p, input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (int'(ROWS[i].port) == p) begin
                send_row(i);
            end
        end
    endtask

    // Both ports run side by side and then all traffic drains
    task automatic run_phase(input int first, input int last);
        fork
            drive_port(0, first, last);
            drive_port(1, first, last);
        join
        do begin
            @(posedge clk);
        end while (pending_count() != 0);
        #1;
    endtask

    // AXI memory model driving its inputs 1 ns after the edge
    always @(posedge clk) begin
        axi_adapter_pkg::axi_aw_t aw_cur;
        axi_adapter_pkg::axi_w_t  w_cur;
        wr_exp_t                  wr_cur;
        logic [31:0]              exp_addr;
        logic                     r_fire;
        logic [31:0]              rnd;
        r_fire = r_valid && r_ready;
        b_next = 1'b0;
        if (aw_valid && aw_ready) begin
            aw_q.push_back(aw);
        end
        if (w_valid && w_ready) begin
            w_q.push_back(w);
        end
        if (aw_q.size() > 0 && w_q.size() > 0) begin
            aw_cur = aw_q.pop_front();
            w_cur = w_q.pop_front();
            if (wr_exp_q[aw_cur.id[0]].size() == 0) begin
                errors++;
                $display("Error at %0t ns: write on the AXI bus that no port issued", $time);
            end else begin
                wr_cur = wr_exp_q[aw_cur.id[0]].pop_front();
                check_value("awaddr", wr_cur.addr, aw_cur.addr);
                check_value("wdata", wr_cur.data, w_cur.data);
                check_value("wstrb", 32'(wr_cur.strb), 32'(w_cur.strb));
            end
            for (int k = 0; k < 4; k++) begin
                if (w_cur.strb[k]) begin
                    mem[aw_cur.addr[9:2]][8*k +: 8] = w_cur.data[8*k +: 8];
                end
            end
            b_next = 1'b1;
        end
        if (ar_valid && ar_ready) begin
            if (check_alt && have_last) begin
                check_value("ar.id port field", 32'(!last_port), 32'(ar.id[0]));
            end
            if (rd_addr_q[ar.id[0]].size() == 0) begin
                errors++;
                $display("Error at %0t ns: read on the AXI bus that no port issued", $time);
            end else begin
                exp_addr = rd_addr_q[ar.id[0]].pop_front();
                check_value("araddr", exp_addr, ar.addr);
            end
            last_port = ar.id[0];
            have_last = 1'b1;
            r_q.push_back(axi_adapter_pkg::axi_r_t'{data: mem[ar.addr[9:2]], id: ar.id,
                                                   resp: axi_adapter_pkg::AXI_RESP_OKAY});
        end
        if (r_fire) begin
            void'(r_q.pop_front());
        end
        #1;
        rnd = next_rand();
        aw_ready = rnd[31] | rnd[30];
        w_ready = rnd[29] | rnd[28];
        ar_ready = rnd[27] | rnd[26];
        rsp_ready = {rnd[25] | rnd[24], rnd[23] | rnd[22]};
        b_valid = b_next;
        if (b_next) begin
            b.id = aw_cur.id;
        end
        // R stays up until taken and then waits 0 to 3 cycles
        if (!r_valid || r_fire) begin
            if (r_fire) begin
                r_wait = int'(rnd[17:16]);
            end
            if (r_wait > 0) begin
                r_wait--;
                r_valid = 1'b0;
            end else if (r_q.size() > 0 && !hold_r) begin
                r_valid = 1'b1;
                r = r_q[0];
            end else begin
                r_valid = 1'b0;
            end
        end
    end

    // Responses must come back in issue order per port
    always @(posedge clk) begin
        axi_adapter_pkg::mem_rsp_t exp_rsp;
        for (int p = 0; p < 2; p++) begin
            if (rsp_valid[p] && rsp_ready[p]) begin
                if (rd_exp_q[p].size() == 0) begin
                    errors++;
                    $display("Error at %0t ns: port %0d returned a response with no read open",
                             $time, p);
                end else begin
                    exp_rsp = rd_exp_q[p].pop_front();
                    check_value($sformatf("rsp[%0d].data", p), exp_rsp.data, rsp[p].data);
                    check_value($sformatf("rsp[%0d].tag", p), 32'(exp_rsp.tag),
                                32'(rsp[p].tag));
                end
            end
        end
    end

    initial begin
        repeat (NUM_ROWS * 50 + 500) @(posedge clk);
        $display("Timeout after %0d cycles with %0d transfers still open",
                 NUM_ROWS * 50 + 500, pending_count());
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        for (int k = 0; k < 256; k++) begin
            mem[k] = 32'hC0DE_0000 | 32'(k);
        end
        rst_n = 1'b0;
        req_valid = '0;
        req = '0;
        rsp_ready = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
        b_valid = 1'b0;
        b = '0;
        hold_r = 1'b0;
        check_alt = 1'b0;
        have_last = 1'b0;
        last_port = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        check_value("aw_valid", 32'd0, 32'(aw_valid));
        check_value("w_valid", 32'd0, 32'(w_valid));
        check_value("ar_valid", 32'd0, 32'(ar_valid));
        check_value("rsp_valid", 32'd0, 32'(rsp_valid));
        check_value("req_ready", 32'd3, 32'(req_ready));
        check_value("b_ready", 32'd1, 32'(b_ready));
        #1;
        run_phase(0, 5);
        // Reads only on both ports so AR IDs must alternate
        have_last = 1'b0;
        check_alt = 1'b1;
        run_phase(6, 11);
        check_alt = 1'b0;
        // R withheld until the ninth read has stalled
        hold_r = 1'b1;
        run_phase(12, 21);
        $display("Finished with %0d testbench errors and %0d assertion failures",
                 errors, i_axi_adapter.i_sva.fail_count);
        if (errors == 0 && i_axi_adapter.i_sva.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
axi_adapter_pkg.sv
tag_index_buffer.sv
stream_reg.sv
req_arbiter.sv
axi_req_master.sv
axi_rsp_router.sv
axi_adapter.sv
axi_adapter_sva.sv
tb_axi_adapter.sv

// File: Bender.yml
package:
  name: axi_adapter

sources:
  - files:
      - axi_adapter_pkg.sv
      - tag_index_buffer.sv
      - stream_reg.sv
      - req_arbiter.sv
      - axi_req_master.sv
      - axi_rsp_router.sv
      - axi_adapter.sv
  - target: test
    files:
      - axi_adapter_sva.sv
      - tb_axi_adapter.sv
